//--- Bender.yml
package:
  name: mmc_rd

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/mmc_pkg.sv
      - src/mmc_clk_gen.sv
      - src/mmc_rd_adv.sv
      - src/mmc_crc_chk.sv
      - src/mmc_rd_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_mmc_rd.sv

//--- list.f
+incdir+src
src/mmc_pkg.sv
src/mmc_clk_gen.sv
src/mmc_rd_adv.sv
src/mmc_crc_chk.sv
src/mmc_rd_top.sv
tb/tb_mmc_rd.sv

//--- src/mmc_clk_gen.sv
`timescale 1ns/1ns
`include "mmc_defs.svh"

module mmc_clk_gen (
  input  logic clk,
  input  logic arst_n_i,
  input  logic enable_i,
  input  logic tick_i,
  output logic mmc_clk_o,
  output logic done_o
);

  localparam int DIV  = `MMC_CLK_DIV;
  localparam int HALF = DIV / 2;
  localparam int CW   = $clog2(DIV);

  localparam logic [CW-1:0] CNT_LAST = CW'(DIV - 1);
  localparam logic [CW-1:0] CNT_HIGH = CW'(HALF);

  // position inside the card clock period, 0 is the first low cycle.
  logic [CW-1:0] cnt_q;

  // a period only leaves count 0 when a tick is asked for.
  // once started it always runs to its end.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (!enable_i) begin
      cnt_q <= '0;
    end else if (cnt_q == CNT_LAST) begin
      cnt_q <= '0;
    end else if (cnt_q != '0 || tick_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign mmc_clk_o = (cnt_q >= CNT_HIGH); // low half, then high half.
  assign done_o    = (cnt_q == CNT_HIGH); // rising edge, dat is sampled here.

  // the sample strobe only ever marks a real rising edge.
  a_done_on_rise: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    done_o |-> !$past(mmc_clk_o)
  );

endmodule

//--- src/mmc_crc_chk.sv
`timescale 1ns/1ns
`include "mmc_defs.svh"

module mmc_crc_chk (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              enable_i,
  input  logic              ack_i,
  input  mmc_pkg::rd_beat_t beat_i,
  output logic              crc_ok_o,
  output logic              crc_err_o
);

  localparam int RX_W = `MMC_CRC_BYTES * 8;

  logic            busy_q; // inside a block, crc register is live.
  logic            cmp_q;
  logic [15:0]     crc_q;
  logic [RX_W-1:0] rx_q;   // received crc, high byte first.

  logic data_beat;
  logic crc_beat;

  // crc-16-ccitt, poly 0x1021, one byte msb first.
  function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] d);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[15] ^ d[i];
      c  = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    end
    return c;
  endfunction

  assign data_beat = ack_i && (beat_i.kind == mmc_pkg::BK_DATA);
  assign crc_beat  = ack_i && (beat_i.kind == mmc_pkg::BK_CRC);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cmp_q  <= 1'b0;
    end else if (!enable_i) begin
      busy_q <= 1'b0;
      cmp_q  <= 1'b0;
    end else begin
      cmp_q <= crc_beat && beat_i.last;
      if (data_beat) begin
        busy_q <= 1'b1;
      end else if (cmp_q) begin
        busy_q <= 1'b0; // next data beat opens a new block.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_beat) begin
      crc_q <= crc16_byte(busy_q ? crc_q : 16'h0000, beat_i.data);
    end
    if (crc_beat) begin
      rx_q <= {rx_q[RX_W-9:0], beat_i.data};
    end
  end

  assign crc_ok_o  = cmp_q && (rx_q == crc_q);
  assign crc_err_o = cmp_q && (rx_q != crc_q);

  // a result only ever follows the final crc beat, and it is one or the other.
  a_one_result: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (crc_ok_o || crc_err_o) |->
      $onehot({crc_ok_o, crc_err_o}) &&
      $past(ack_i && beat_i.last && beat_i.kind == mmc_pkg::BK_CRC)
  );

endmodule

//--- src/mmc_defs.svh
`ifndef MMC_DEFS_SVH
`define MMC_DEFS_SVH

// data bytes in one block.
`define MMC_BLK_SIZE 512

// width of the byte counter, log2 of the block size.
`define MMC_BLK_LOG2 9

// crc bytes that follow the data, sent serially on dat0.
`define MMC_CRC_BYTES 2

// clk cycles per card clock period, must be even and at least 2.
`define MMC_CLK_DIV 4

`endif // MMC_DEFS_SVH

//--- src/mmc_pkg.sv
package mmc_pkg;

  // data bus width of the card, 3 decodes as 8 bit.
  typedef enum logic [1:0] {
    BW_1 = 2'd0,
    BW_4 = 2'd1,
    BW_8 = 2'd2
  } bus_width_e;

  // what a delivered byte carries.
  typedef enum logic [1:0] {
    BK_DATA = 2'd0,
    BK_CRC  = 2'd1,
    BK_STOP = 2'd2
  } beat_kind_e;

  // one byte handed to the consumer.
  typedef struct packed {
    logic [7:0] data;
    beat_kind_e kind;
    logic       last; // final data byte or second crc byte.
  } rd_beat_t;

endpackage

//--- src/mmc_rd_adv.sv
`timescale 1ns/1ns
`include "mmc_defs.svh"

module mmc_rd_adv (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                enable_i,
  input  mmc_pkg::bus_width_e bus_width_i,
  input  logic [7:0]          mmc_dat_i,
  input  logic                bus_req_i,
  input  logic                clk_done_i,
  output mmc_pkg::rd_beat_t   beat_o,
  output logic                bus_ack_o,
  output logic                clk_tick_o
);

  localparam int BLK_W = `MMC_BLK_LOG2;

  localparam logic [BLK_W-1:0] LAST_DATA = BLK_W'(`MMC_BLK_SIZE - 1);
  localparam logic [BLK_W-1:0] LAST_CRC  = BLK_W'(`MMC_CRC_BYTES - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEARCH,
    ST_DATA,
    ST_CRC,
    ST_STOP
  } state_e;

  // how the dat lines fill the accumulator.
  typedef enum logic [1:0] {
    SH_1,
    SH_4,
    SH_8
  } shift_e;

  state_e            state_q;
  logic [BLK_W-1:0]  cnt_q;  // beat within the phase.
  logic [2:0]        bit_q;  // samples taken for the current byte.
  logic [7:0]        acc_q;
  logic              req_q;
  logic              ack_q;
  mmc_pkg::rd_beat_t beat_q;

  shift_e                 shift;
  logic [2:0]             targ;
  logic [7:0]             acc_nxt;
  logic                   in_xfer;
  logic                   byte_done;
  mmc_pkg::beat_kind_e    kind;
  logic                   last;

  assign in_xfer = (state_q == ST_DATA) || (state_q == ST_CRC) || (state_q == ST_STOP);

  // crc bytes are always serial on dat0, stop is a single sample.
  always_comb begin
    shift = SH_8;
    if (state_q == ST_CRC) begin
      shift = SH_1;
    end else if (state_q == ST_DATA) begin
      case (bus_width_i)
        mmc_pkg::BW_1: shift = SH_1;
        mmc_pkg::BW_4: shift = SH_4;
        default:       shift = SH_8;
      endcase
    end
  end

  always_comb begin
    case (shift)
      SH_1: begin
        targ    = 3'd7;
        acc_nxt = {acc_q[6:0], mmc_dat_i[0]}; // msb first.
      end
      SH_4: begin
        targ    = 3'd1;
        acc_nxt = {acc_q[3:0], mmc_dat_i[3:0]}; // high nibble first.
      end
      default: begin
        targ    = 3'd0;
        acc_nxt = mmc_dat_i;
      end
    endcase
  end

  assign byte_done = in_xfer && clk_done_i && (bit_q == targ);

  always_comb begin
    case (state_q)
      ST_DATA: kind = mmc_pkg::BK_DATA;
      ST_CRC:  kind = mmc_pkg::BK_CRC;
      default: kind = mmc_pkg::BK_STOP;
    endcase
  end

  assign last = ((state_q == ST_DATA) && (cnt_q == LAST_DATA)) ||
                ((state_q == ST_CRC) && (cnt_q == LAST_CRC));

  // phase machine, it advances on the ack of each beat.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else if (!enable_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          state_q <= ST_SEARCH;
        end
        ST_SEARCH: begin
          if (clk_done_i && !mmc_dat_i[0]) begin // start bit.
            state_q <= ST_DATA;
            cnt_q   <= '0;
            bit_q   <= '0;
          end
        end
        default: begin
          if (clk_done_i) begin
            bit_q <= (bit_q == targ) ? 3'd0 : bit_q + 3'd1;
          end
          if (ack_q) begin
            case (state_q)
              ST_DATA: begin
                if (cnt_q == LAST_DATA) begin
                  cnt_q   <= '0;
                  state_q <= ST_CRC;
                end else begin
                  cnt_q <= cnt_q + 1'b1;
                end
              end
              ST_CRC: begin
                if (cnt_q == LAST_CRC) begin
                  cnt_q   <= '0;
                  state_q <= ST_STOP;
                end else begin
                  cnt_q <= cnt_q + 1'b1;
                end
              end
              default: begin
                state_q <= ST_SEARCH;
              end
            endcase
          end
        end
      endcase
    end
  end

  // request latch and ack strobe.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= 1'b0;
      ack_q <= 1'b0;
    end else if (!enable_i) begin
      req_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= byte_done;
      if (ack_q) begin
        req_q <= 1'b0;
      end
      if (bus_req_i) begin
        req_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clk_done_i) begin
      acc_q <= acc_nxt;
    end
    if (byte_done) begin
      beat_q.data <= acc_nxt;
      beat_q.kind <= kind;
      beat_q.last <= last;
    end
  end

  assign beat_o    = beat_q;
  assign bus_ack_o = ack_q;

  // without a pending request the card clock stops, so no data is lost.
  assign clk_tick_o = (state_q == ST_SEARCH) || (in_xfer && req_q && !ack_q);

  a_ack_in_xfer: assert property (
    @(posedge clk) disable iff (!arst_n_i || !enable_i)
    bus_ack_o |-> (state_q != ST_IDLE) && (state_q != ST_SEARCH)
  );

  // while searching the clock keeps running and dat0 keeps being sampled.
  a_search_ticks: assert property (
    @(posedge clk) disable iff (!arst_n_i || !enable_i)
    (state_q == ST_SEARCH) |->
      clk_tick_o ##[0:`MMC_CLK_DIV] (clk_done_i || state_q != ST_SEARCH)
  );

endmodule

//--- src/mmc_rd_top.sv
`timescale 1ns/1ns

module mmc_rd_top (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                enable_i,
  input  mmc_pkg::bus_width_e bus_width_i,
  input  logic [7:0]          mmc_dat_i,
  input  logic                bus_req_i,
  output logic                mmc_clk_o,
  output logic                bus_ack_o,
  output mmc_pkg::rd_beat_t   beat_o,
  output logic                crc_ok_o,
  output logic                crc_err_o
);

  logic clk_tick; // reader asks for card clocks.
  logic clk_done; // sample point, card clock rises.

  mmc_clk_gen u_clk_gen (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .enable_i  (enable_i),
    .tick_i    (clk_tick),
    .mmc_clk_o (mmc_clk_o),
    .done_o    (clk_done)
  );

  mmc_rd_adv u_rd_adv (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .enable_i    (enable_i),
    .bus_width_i (bus_width_i),
    .mmc_dat_i   (mmc_dat_i),
    .bus_req_i   (bus_req_i),
    .clk_done_i  (clk_done),
    .beat_o      (beat_o),
    .bus_ack_o   (bus_ack_o),
    .clk_tick_o  (clk_tick)
  );

  // the checker snoops the consumer port.
  mmc_crc_chk u_crc_chk (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .enable_i  (enable_i),
    .ack_i     (bus_ack_o),
    .beat_i    (beat_o),
    .crc_ok_o  (crc_ok_o),
    .crc_err_o (crc_err_o)
  );

endmodule

//--- tb/tb_mmc_rd.sv
`timescale 1ns/1ns
`include "mmc_defs.svh"

module tb_mmc_rd;

  localparam int BLK       = `MMC_BLK_SIZE;
  localparam int N_BEATS   = `MMC_BLK_SIZE + `MMC_CRC_BYTES + 1;
  localparam int WAIT_MAX  = 2000; // clk cycles allowed for any single wait.
  localparam int PAUSE_LEN = 200;

  logic                clk;
  logic                arst_n_i;
  logic                enable_i;
  mmc_pkg::bus_width_e bus_width_i;
  logic [7:0]          mmc_dat_i;
  logic                bus_req_i;
  logic                mmc_clk_o;
  logic                bus_ack_o;
  mmc_pkg::rd_beat_t   beat_o;
  logic                crc_ok_o;
  logic                crc_err_o;

  logic [31:0]       lfsr_q;
  logic [7:0]        blk_data [0:BLK-1];
  int                req_delay [0:N_BEATS-1]; // consumer delay before each request.
  int                idle_n;
  logic [15:0]       sent_crc;
  mmc_pkg::rd_beat_t exp_q [$];
  logic              abort;   // block was cut off so card and consumer give up.
  int                ok_cnt;
  int                err_cnt;
  logic              crc_last_seen;

  mmc_rd_top u_mmc_rd_top (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .enable_i    (enable_i),
    .bus_width_i (bus_width_i),
    .mmc_dat_i   (mmc_dat_i),
    .bus_req_i   (bus_req_i),
    .mmc_clk_o   (mmc_clk_o),
    .bus_ack_o   (bus_ack_o),
    .beat_o      (beat_o),
    .crc_ok_o    (crc_ok_o),
    .crc_err_o   (crc_err_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%0t ns: %s", $time, what);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                       input string what);
    if (expected !== actual) begin
      $display("ERROR at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // long division of the block followed by 16 zero bits by x^16+x^12+x^5+1.
  function automatic logic [15:0] crc16_ref(input int nbytes);
    logic [16:0] r;
    logic [7:0]  b;
    r = '0;
    for (int i = 0; i < nbytes + 2; i++) begin
      b = (i < nbytes) ? blk_data[i] : 8'h00;
      for (int k = 7; k >= 0; k--) begin
        r = {r[15:0], b[k]};
        if (r[16]) begin
          r = r ^ 17'h11021;
        end
      end
    end
    return r[15:0];
  endfunction

  task automatic wait_card_fall();
    logic prev;
    logic fell;
    int   n;
    prev = mmc_clk_o;
    fell = 1'b0;
    n    = 0;
    while (!fell && !abort && n < WAIT_MAX) begin
      @(negedge clk);
      fell = prev && !mmc_clk_o;
      prev = mmc_clk_o;
      n++;
    end
    if (!fell && !abort) begin
      report_failure("timeout waiting for a falling edge of the card clock");
    end
  endtask

  // the card changes its lines only after the card clock falls.
  task automatic drive_period(input logic [7:0] v);
    wait_card_fall();
    if (!abort) begin
      mmc_dat_i = v;
    end
  endtask

  task automatic send_block(input mmc_pkg::bus_width_e bw);
    logic [7:0] b;
    for (int i = 0; i < idle_n; i++) begin
      wait_card_fall();
      if (abort) begin
        return;
      end
    end
    mmc_dat_i = (bw == mmc_pkg::BW_1) ? 8'hFE : 8'h00; // start bit.
    for (int i = 0; i < BLK; i++) begin
      b = blk_data[i];
      case (bw)
        mmc_pkg::BW_1: begin
          for (int k = 7; k >= 0; k--) begin
            drive_period({7'h7F, b[k]});
          end
        end
        mmc_pkg::BW_4: begin
          drive_period({4'hF, b[7:4]});
          drive_period({4'hF, b[3:0]});
        end
        default: begin
          drive_period(b);
        end
      endcase
      if (abort) begin
        return;
      end
    end
    for (int k = 15; k >= 0; k--) begin
      drive_period({7'h7F, sent_crc[k]}); // crc is serial on dat0.
    end
    drive_period(8'hFF); // stop period.
  endtask

  task automatic pulse_req(input int d);
    repeat (d + 1) @(negedge clk);
    bus_req_i = 1'b1;
    @(negedge clk);
    bus_req_i = 1'b0;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    @(negedge clk);
    while (!bus_ack_o && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (!bus_ack_o) begin
      report_failure("timeout waiting for an ack from the reader");
    end
  endtask

  // the card clock may finish its period and then has to stay quiet.
  task automatic watch_pause();
    int   rises;
    logic prev;
    rises = 0;
    prev  = mmc_clk_o;
    for (int i = 0; i < PAUSE_LEN; i++) begin
      @(negedge clk);
      if (i >= `MMC_CLK_DIV && !prev && mmc_clk_o) begin
        rises++;
      end
      prev = mmc_clk_o;
    end
    check(0, rises, "card clock rising edges while the consumer pauses");
  endtask

  task automatic consume_block(input int pause_at, input int drop_at);
    int acks;
    acks = 0;
    pulse_req(req_delay[0]);
    while (acks < N_BEATS) begin
      wait_ack();
      acks++;
      if (acks == drop_at) begin
        enable_i = 1'b0; // cut the reader off mid-block.
        abort    = 1'b1;
        return;
      end
      if (acks == pause_at) begin
        watch_pause();
      end
      if (acks < N_BEATS) begin
        pulse_req(req_delay[acks]);
      end
    end
  endtask

  task automatic build_block(input logic flip);
    logic [31:0]       v;
    logic [15:0]       crc;
    mmc_pkg::rd_beat_t b;
    for (int i = 0; i < BLK; i++) begin
      take_bits(8, v);
      blk_data[i] = v[7:0];
    end
    take_bits(5, v);
    idle_n = 1 + v % 20;
    for (int i = 0; i < N_BEATS; i++) begin
      take_bits(3, v);
      req_delay[i] = v % 7;
    end
    crc      = crc16_ref(BLK);
    sent_crc = crc;
    if (flip) begin
      take_bits(4, v);
      sent_crc[v[3:0]] = ~crc[v[3:0]];
    end
    exp_q.delete();
    for (int i = 0; i < BLK; i++) begin
      b.data = blk_data[i];
      b.kind = mmc_pkg::BK_DATA;
      b.last = (i == BLK - 1);
      exp_q.push_back(b);
    end
    b.data = sent_crc[15:8]; // high byte first.
    b.kind = mmc_pkg::BK_CRC;
    b.last = 1'b0;
    exp_q.push_back(b);
    b.data = sent_crc[7:0];
    b.last = 1'b1;
    exp_q.push_back(b);
    b.data = 8'hFF;
    b.kind = mmc_pkg::BK_STOP;
    b.last = 1'b0;
    exp_q.push_back(b);
  endtask

  task automatic run_block(input mmc_pkg::bus_width_e bw, input logic flip,
                           input int pause_at, input int drop_at);
    bus_width_i = bw;
    build_block(flip);
    ok_cnt  = 0;
    err_cnt = 0;
    fork
      send_block(bw);
      consume_block(pause_at, drop_at);
    join
    @(negedge clk);
    if (drop_at == 0) begin
      check(0, exp_q.size(), "beats still expected after the stop beat");
      check(flip ? 0 : 1, ok_cnt, "crc_ok_o pulses in the block");
      check(flip ? 1 : 0, err_cnt, "crc_err_o pulses in the block");
    end else begin
      repeat (2) @(negedge clk);
      exp_q.delete();
      mmc_dat_i = 8'hFF; // card goes back to idle.
      abort     = 1'b0;
      enable_i  = 1'b1;
      @(negedge clk);
    end
  endtask

  initial begin : compare_beats
    mmc_pkg::rd_beat_t exp_beat;
    int                idx;
    forever begin
      @(negedge clk);
      if (arst_n_i) begin
        if (crc_ok_o || crc_err_o) begin
          check(1, crc_last_seen, "crc result one cycle after the last crc beat");
        end
        if (crc_ok_o) begin
          ok_cnt++;
        end
        if (crc_err_o) begin
          err_cnt++;
        end
        crc_last_seen = bus_ack_o && beat_o.kind == mmc_pkg::BK_CRC && beat_o.last;
        if (bus_ack_o) begin
          if (exp_q.size() == 0) begin
            report_failure("the reader delivered a beat that was not expected");
          end else begin
            idx      = N_BEATS - exp_q.size();
            exp_beat = exp_q.pop_front();
            check(exp_beat.data, beat_o.data, $sformatf("beat %0d data", idx));
            check(exp_beat.kind, beat_o.kind, $sformatf("beat %0d kind", idx));
            check(exp_beat.last, beat_o.last, $sformatf("beat %0d last", idx));
          end
        end
      end
    end
  end

  initial begin : test_seq
    arst_n_i      = 1'b0;
    enable_i      = 1'b0;
    bus_width_i   = mmc_pkg::BW_1;
    mmc_dat_i     = 8'hFF;
    bus_req_i     = 1'b0;
    lfsr_q        = 32'h188c5c55;
    abort         = 1'b0;
    ok_cnt        = 0;
    err_cnt       = 0;
    crc_last_seen = 1'b0;
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
    enable_i = 1'b1;
    repeat (2) @(negedge clk);

    run_block(mmc_pkg::BW_1, 1'b0, 0, 0);
    run_block(mmc_pkg::BW_4, 1'b0, 0, 0);
    run_block(mmc_pkg::BW_8, 1'b0, 0, 0);
    run_block(mmc_pkg::BW_4, 1'b1, 0, 0);   // one crc bit flipped.
    run_block(mmc_pkg::BW_1, 1'b0, 200, 0); // consumer stalls mid-block.
    run_block(mmc_pkg::BW_8, 1'b0, 0, 100);
    run_block(mmc_pkg::BW_4, 1'b0, 0, 0);   // fresh block after the enable drop.

    $display("Test OK");
    $finish;
  end

endmodule
